//--- source/bch_pkg.sv
package bch_pkg;

	// field and code shape.
	localparam int gf_m = 5;
	localparam int gf_n = 31; // 2^gf_m - 1 points in the field.
	localparam int bch_t = 2;
	localparam int cnt_w = 2;

	// x^5 + x^2 + 1.
	localparam logic [gf_m:0] gf_poly = 6'b100101;

	// root collector state encodings.
	localparam logic [2:0] col_idle = 3'd0;
	localparam logic [2:0] col_eval = 3'd1;
	localparam logic [2:0] col_ack_hi = 3'd2;
	localparam logic [2:0] col_ack_lo = 3'd3;
	localparam logic [2:0] col_resume = 3'd4;
	localparam logic [2:0] col_sum = 3'd5;

	// shift-and-add multiply, reduced by gf_poly on every shift.
	function automatic logic [gf_m-1:0] gf_mul(
		input logic [gf_m-1:0] a,
		input logic [gf_m-1:0] b
	);
		logic [gf_m-1:0] acc;
		logic [gf_m-1:0] sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i])
				acc = acc ^ sh;
			if (sh[gf_m-1])
				sh = (sh << 1) ^ gf_poly[gf_m-1:0];
			else
				sh = sh << 1;
		end
		return acc;
	endfunction

	// alpha^e, exponent taken modulo the field order.
	function automatic logic [gf_m-1:0] gf_alpha_pow(input int e);
		logic [gf_m-1:0] r;
		int n;
		r = 1;
		n = e % gf_n;
		if (n < 0)
			n = n + gf_n;
		for (int i = 0; i < n; i++)
			r = gf_mul(r, 2); // alpha is x.
		return r;
	endfunction

	// position view of an output word.
	typedef struct packed {
		logic [2:0] pad;
		logic [gf_m-1:0] pos;
	} root_loc_t;

	// summary view, sent last with out_end high.
	typedef struct packed {
		logic fail;
		logic [4:0] pad;
		logic [cnt_w-1:0] cnt;
	} root_sum_t;

	typedef union packed {
		root_loc_t loc;
		root_sum_t sum;
	} root_word_t;

endpackage

//--- source/chien_intake.sv
`timescale 1ns/1ps

module chien_intake import bch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic in_req,
	input logic [(bch_t+1)*gf_m-1:0] in_sigma,
	output logic in_ack,
	input logic search_busy,
	output logic start,
	output logic [bch_t:0][gf_m-1:0] coef,
	output logic [cnt_w-1:0] sigma_deg
);

	// in_ack doubles as the handshake state.
	// low means idle and ready for a new polynomial.
	logic take;

	assign take = !in_ack && in_req && !search_busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			in_ack <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= take; // one pulse per accepted polynomial.
			if (take)
				in_ack <= 1'b1;
			else if (in_ack && !in_req)
				in_ack <= 1'b0; // producer released, close the handshake.
		end
	end

	// polynomial holding register, coefficient i sits at bits 5i upward.
	always_ff @(posedge clk) begin
		if (take)
			coef <= in_sigma;
	end

	// degree is the index of the highest nonzero coefficient.
	always_comb begin
		sigma_deg = '0;
		for (int i = 1; i <= bch_t; i++) begin
			if (coef[i] != '0)
				sigma_deg = cnt_w'(i);
		end
	end

	// a search in flight must finish its summary before the next intake.
	a_no_ack_while_busy: assert property (
		@(posedge clk) disable iff (rst)
		$rose(in_ack) |-> !search_busy
	);

endmodule

//--- source/chien_cell.sv
`timescale 1ns/1ps

module chien_cell import bch_pkg::*; #(
	parameter int idx = 0
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic step,
	input logic [gf_m-1:0] coef,
	output logic [gf_m-1:0] term
);

	// fixed multiplier for this coefficient position.
	localparam logic [gf_m-1:0] alpha_idx = gf_alpha_pow(idx);

	logic [gf_m-1:0] term_nxt;

	// one shared multiplier, fed by the coefficient on start.
	assign term_nxt = gf_mul(start ? coef : term, alpha_idx);

	always_ff @(posedge clk) begin
		if (rst)
			term <= '0;
		else if (start || step)
			term <= term_nxt; // sigma_idx * alpha^(idx*k).
	end

	// the collector only steps between searches' starts.
	a_start_step_excl: assert property (
		@(posedge clk) disable iff (rst)
		!(start && step)
	);

endmodule

//--- source/root_collector.sv
`timescale 1ns/1ps

module root_collector import bch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [cnt_w-1:0] sigma_deg,
	input logic [bch_t:0][gf_m-1:0] term,
	output logic step,
	output logic search_busy,
	output logic out_req,
	input logic out_ack,
	output root_word_t out_word,
	output logic out_end
);

	logic [2:0] state;
	logic [gf_m-1:0] k; // current point, sigma(alpha^k) on the terms.
	logic [cnt_w-1:0] root_cnt;
	logic [gf_m-1:0] sum;
	logic all_zero;
	logic last_pt;
	logic hit;

	// polynomial value at the current point.
	always_comb begin
		sum = '0;
		all_zero = 1'b1;
		for (int i = 0; i <= bch_t; i++) begin
			sum = sum ^ term[i];
			if (term[i] != '0)
				all_zero = 1'b0;
		end
	end

	// terms stay nonzero for any nonzero coefficient, so all_zero
	// marks the zero polynomial; it never reports roots.
	assign last_pt = (k == gf_m'(gf_n));
	assign hit = (state == col_eval) && (sum == '0) && !all_zero;

	// cells advance after each point evaluated without a root,
	// and once more after a reported root.
	assign step = ((state == col_eval) && !hit && !last_pt) || (state == col_resume);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= col_idle;
			search_busy <= 1'b0;
			out_req <= 1'b0;
			out_end <= 1'b0;
			k <= '0;
			root_cnt <= '0;
		end else begin
			case (state)
				col_idle: begin
					if (start) begin
						state <= col_eval;
						search_busy <= 1'b1;
						k <= 1;
						root_cnt <= '0;
					end
				end
				col_eval: begin
					if (hit) begin
						out_word.loc.pad <= '0;
						out_word.loc.pos <= gf_m'(gf_n) - k; // 0 for k = 31.
						out_end <= 1'b0;
						out_req <= 1'b1;
						root_cnt <= root_cnt + 1'b1;
						state <= col_ack_hi;
					end else if (last_pt) begin
						state <= col_sum;
					end else begin
						k <= k + 1'b1;
					end
				end
				col_sum: begin
					// count differing from the degree means uncorrectable.
					out_word.sum.fail <= all_zero || (root_cnt != sigma_deg);
					out_word.sum.pad <= '0;
					out_word.sum.cnt <= root_cnt;
					out_end <= 1'b1;
					out_req <= 1'b1;
					state <= col_ack_hi;
				end
				col_ack_hi: begin
					if (out_ack) begin
						out_req <= 1'b0;
						state <= col_ack_lo;
					end
				end
				col_ack_lo: begin
					if (!out_ack) begin
						if (out_end) begin
							state <= col_idle; // summary done, free the intake.
							search_busy <= 1'b0;
						end else if (last_pt) begin
							state <= col_sum;
						end else begin
							state <= col_resume;
						end
					end
				end
				col_resume: begin
					k <= k + 1'b1; // cells move on to the same point.
					state <= col_eval;
				end
				default: state <= col_idle;
			endcase
		end
	end

	// the consumer may sample at any time while out_req is up.
	a_word_stable: assert property (
		@(posedge clk) disable iff (rst)
		out_req && $past(out_req) |-> $stable(out_word) && $stable(out_end)
	);

endmodule

//--- source/chien_top.sv
`timescale 1ns/1ps

module chien_top import bch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic in_req,
	input logic [(bch_t+1)*gf_m-1:0] in_sigma,
	output logic in_ack,
	output logic out_req,
	input logic out_ack,
	output root_word_t out_word,
	output logic out_end
);

	logic start;
	logic step;
	logic search_busy;
	logic [bch_t:0][gf_m-1:0] coef;
	logic [bch_t:0][gf_m-1:0] term;
	logic [cnt_w-1:0] sigma_deg;

	chien_intake u_intake (
		.clk(clk),
		.rst(rst),
		.in_req(in_req),
		.in_sigma(in_sigma),
		.in_ack(in_ack),
		.search_busy(search_busy),
		.start(start),
		.coef(coef),
		.sigma_deg(sigma_deg)
	);

	// one cell per locator coefficient.
	for (genvar i = 0; i <= bch_t; i++) begin : g_cell
		chien_cell #(
			.idx(i)
		) u_cell (
			.clk(clk),
			.rst(rst),
			.start(start),
			.step(step),
			.coef(coef[i]),
			.term(term[i])
		);
	end

	root_collector u_collector (
		.clk(clk),
		.rst(rst),
		.start(start),
		.sigma_deg(sigma_deg),
		.term(term),
		.step(step),
		.search_busy(search_busy),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_word(out_word),
		.out_end(out_end)
	);

endmodule

//--- dv/chien_model.svh
`ifndef CHIEN_MODEL_SVH
`define CHIEN_MODEL_SVH

// one Fibonacci LFSR step, taps at 32 22 2 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// multiply by x, then reduce by x^5 + x^2 + 1.
function automatic logic [4:0] times_x(input logic [4:0] a);
	if (a[4])
		return {a[3:0], 1'b0} ^ 5'h05;
	return {a[3:0], 1'b0};
endfunction

// alpha^e by walking the powers from 1.
function automatic logic [4:0] alpha_to(input int e);
	logic [4:0] p;
	p = 5'h01;
	for (int i = 0; i < e % 31; i++)
		p = times_x(p);
	return p;
endfunction

// discrete log, only meaningful for a nonzero element.
function automatic int field_log(input logic [4:0] a);
	logic [4:0] p;
	int e;
	p = 5'h01;
	e = 0;
	while (p != a && e < 31) begin
		p = times_x(p);
		e++;
	end
	return e;
endfunction

// product through the log tables, zero handled apart.
function automatic logic [4:0] field_mul(input logic [4:0] a, input logic [4:0] b);
	if (a == 5'h00 || b == 5'h00)
		return 5'h00;
	return alpha_to(field_log(a) + field_log(b));
endfunction

// sigma(alpha^k), coefficient i at bits 5i upward.
function automatic logic [4:0] eval_locator(input logic [14:0] sigma, input int k);
	logic [4:0] acc;
	acc = sigma[4:0];
	acc = acc ^ field_mul(sigma[9:5], alpha_to(k));
	acc = acc ^ field_mul(sigma[14:10], alpha_to(2 * k));
	return acc;
endfunction

// index of the highest nonzero coefficient, 0 for a constant.
function automatic int locator_degree(input logic [14:0] sigma);
	int deg;
	deg = 0;
	for (int i = 1; i <= 2; i++) begin
		if (sigma[5*i +: 5] != 5'h00)
			deg = i;
	end
	return deg;
endfunction

`endif

//--- dv/chien_tb.sv
`timescale 1ns/1ps

module chien_tb;

	localparam int num_polys = 60;
	localparam int wait_limit = 400; // cycles allowed for one handshake phase.

	logic clk;
	logic rst;
	logic in_req;
	logic [14:0] in_sigma;
	logic in_ack;
	logic out_req;
	logic out_ack;
	logic [7:0] out_word;
	logic out_end;

	logic [31:0] lfsr_state;
	logic [8:0] exp_q[$]; // {end, word} in the order they must appear.
	int ends_done; // summaries fully acknowledged.
	int accepted; // polynomials taken by the intake.
	logic all_done;
	logic [4:0] model_roots[2];
	int model_cnt;
	logic constructed;
	int chosen_cnt;
	logic [4:0] chosen_pos[2];
	logic prev_req;
	logic [7:0] prev_word;
	logic prev_end;

	`include "chien_model.svh"

	chien_top DUT (
		.clk(clk),
		.rst(rst),
		.in_req(in_req),
		.in_sigma(in_sigma),
		.in_ack(in_ack),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_word(out_word),
		.out_end(out_end)
	);

	always #5 clk = ~clk;

	task automatic stop_with_failure();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic timed_out(input string what);
		$display("timeout while waiting for %s", what);
		stop_with_failure();
	endtask

	// one LFSR step per bit, newest bit at the bottom.
	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// brute force over all 31 points, appended behind earlier searches.
	task automatic predict_outputs(input logic [14:0] sigma);
		logic fail;
		model_cnt = 0;
		if (sigma != 15'h0000) begin
			for (int k = 1; k <= 31; k++) begin
				if (eval_locator(sigma, k) == 5'h00) begin
					if (model_cnt < 2)
						model_roots[model_cnt] = 5'((31 - k) % 31);
					exp_q.push_back({1'b0, 3'b000, 5'((31 - k) % 31)});
					model_cnt++;
				end
			end
		end
		fail = (sigma == 15'h0000) || (model_cnt != locator_degree(sigma));
		exp_q.push_back({1'b1, fail, 5'b00000, 2'(model_cnt)});
	endtask

	// picks zero, constructed or fully random locators.
	task automatic make_poly(input int n, output logic [14:0] sigma);
		logic [31:0] sel;
		logic [31:0] r;
		int p1;
		int p2;
		constructed = 1'b0;
		if (n == 0 || n == num_polys / 2) begin
			sigma = 15'h0000;
			return;
		end
		draw_bits(2, sel);
		if (sel < 2) begin
			constructed = 1'b1;
			draw_bits(2, r);
			chosen_cnt = int'(r % 3);
			draw_bits(5, r);
			p1 = int'(r % 31);
			draw_bits(5, r);
			p2 = int'(r % 31);
			if (p2 == p1)
				p2 = (p1 + 1) % 31;
			if (chosen_cnt == 0)
				sigma = {5'h00, 5'h00, 5'h01};
			else if (chosen_cnt == 1)
				sigma = {5'h00, alpha_to(p1), 5'h01};
			else
				sigma = {alpha_to(p1 + p2), alpha_to(p1) ^ alpha_to(p2), 5'h01};
			chosen_pos[0] = 5'(chosen_cnt == 2 && p2 > p1 ? p2 : p1); // larger first.
			chosen_pos[1] = 5'(p2 > p1 ? p1 : p2);
		end else begin
			draw_bits(15, r);
			sigma = r[14:0];
			if (sel == 3 && sigma[14:10] == 5'h00)
				sigma[14:10] = 5'h01; // keep this branch at degree 2.
		end
	endtask

	task automatic send_poly(input logic [14:0] sigma);
		int t;
		predict_outputs(sigma);
		in_sigma = sigma;
		in_req = 1'b1;
		t = 0;
		while (!in_ack) begin
			@(negedge clk);
			t++;
			if (t > wait_limit)
				timed_out("in_ack to rise");
		end
		// every earlier summary must be through before a new intake.
		check_value("summaries done at in_ack", ends_done, accepted);
		accepted++;
		in_req = 1'b0;
		t = 0;
		while (in_ack) begin
			@(negedge clk);
			t++;
			if (t > wait_limit)
				timed_out("in_ack to fall");
		end
	endtask

	initial begin
		logic [14:0] sigma;
		logic [31:0] r;
		int t;
		clk = 1'b0;
		rst = 1'b1;
		in_req = 1'b0;
		in_sigma = '0;
		out_ack = 1'b0;
		lfsr_state = 32'h8f54_d840;
		ends_done = 0;
		accepted = 0;
		all_done = 1'b0;
		prev_req = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int n = 0; n < num_polys; n++) begin
			make_poly(n, sigma);
			send_poly(sigma);
			if (constructed) begin
				check_value("model root count", model_cnt, chosen_cnt);
				for (int i = 0; i < chosen_cnt; i++)
					check_value("model root position", model_roots[i], chosen_pos[i]);
			end
			draw_bits(2, r);
			if (r[1])
				repeat (r[0] + 1) @(negedge clk); // otherwise back to back.
		end
		t = 0;
		while (ends_done < num_polys) begin
			@(negedge clk);
			t++;
			if (t > wait_limit * 4)
				timed_out("the last summary");
		end
		repeat (40) begin
			@(negedge clk);
			check_value("out_req after the last summary", out_req, 1'b0);
		end
		all_done = 1'b1;
		$display("TESTS PASSED");
		$finish;
	end

	// consumer with random ack delays of 0 to 7 cycles.
	initial begin
		logic [8:0] exp_w;
		logic [31:0] d;
		int idle;
		int t;
		idle = 0;
		while (!all_done) begin
			@(negedge clk);
			if (!rst && out_req) begin
				idle = 0;
				if (exp_q.size() == 0) begin
					$display("output word offered when none was expected");
					stop_with_failure();
				end
				exp_w = exp_q.pop_front();
				check_value("out_end", out_end, exp_w[8]);
				check_value("out_word", out_word, exp_w[7:0]);
				draw_bits(3, d);
				repeat (d) @(negedge clk);
				out_ack = 1'b1;
				t = 0;
				while (out_req) begin
					@(negedge clk);
					t++;
					if (t > wait_limit)
						timed_out("out_req to fall");
				end
				draw_bits(3, d);
				repeat (d) @(negedge clk);
				out_ack = 1'b0;
				if (exp_w[8])
					ends_done++;
			end else if (exp_q.size() != 0) begin
				idle++;
				if (idle > wait_limit)
					timed_out("the next output word");
			end
		end
	end

	// word and end flag must hold while offered.
	always @(negedge clk) begin
		if (!rst && out_req && prev_req) begin
			check_value("out_word while out_req high", out_word, prev_word);
			check_value("out_end while out_req high", out_end, prev_end);
		end
		prev_req = out_req;
		prev_word = out_word;
		prev_end = out_end;
	end

endmodule

//--- files.f
+incdir+dv
source/bch_pkg.sv
source/chien_intake.sv
source/chien_cell.sv
source/root_collector.sv
source/chien_top.sv
dv/chien_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds with Verilator, runs, and scans the log for the fail message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module chien_tb \
	-f files.f --Mdir obj_dir -o chien_sim > build.log 2>&1 \
	&& ./obj_dir/chien_sim > sim.log 2>&1 \
	|| { cat build.log; cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log \
	&& { echo "simulation reported a failure"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
